//--- hw/tim_params.svh
`ifndef TIM_PARAMS_SVH
`define TIM_PARAMS_SVH

// ##############################
// memory geometry
// ##############################

// number of word-interleaved banks, a power of two
`define TIM_BANKS 4

// 64-bit words held by each bank, a power of two
`define TIM_DEPTH 64

// processor byte address width
`define TIM_ADDR_W 32

`define TIM_BANK_W $clog2(`TIM_BANKS)
`define TIM_WORD_W $clog2(`TIM_DEPTH)

`endif

//--- hw/tim_pkg.sv
`include "tim_params.svh"

package tim_pkg;

  typedef logic [`TIM_ADDR_W-1:0] tim_addr_t;  // byte address
  typedef logic [63:0] tim_data_t;
  typedef logic [7:0] tim_strb_t;               // one strobe per byte of a word
  typedef logic [`TIM_BANK_W-1:0] bank_sel_t;
  typedef logic [`TIM_WORD_W-1:0] word_idx_t;

  // ##############################
  // processor side
  // ##############################

  // a zero wstrb marks a read
  typedef struct packed {
    logic valid;
    tim_addr_t addr;
    tim_data_t wdata;
    tim_strb_t wstrb;
  } tim_req_t;

  typedef struct packed {
    logic ready;
    tim_data_t rdata;
  } tim_rsp_t;

  // ##############################
  // bank side
  // ##############################

  typedef struct packed {
    logic wen;
    word_idx_t waddr;
    word_idx_t raddr;
    tim_data_t wdata;
  } bank_in_t;

  typedef struct packed {
    tim_data_t rdata;
  } bank_out_t;

endpackage

//--- hw/tim_bank_ram.sv
`include "tim_params.svh"

module tim_bank_ram (
  input logic clock,
  input tim_pkg::bank_in_t bank_in,
  output tim_pkg::bank_out_t bank_out
);

  import tim_pkg::*;

  // contents power up as zero
  tim_data_t mem [`TIM_DEPTH] = '{default: '0};

  always_ff @(posedge clock) begin
    if (bank_in.wen) begin
      mem[bank_in.waddr] <= bank_in.wdata;
    end
  end

  // registered read, a same-cycle write to the word is not seen here
  always_ff @(posedge clock) begin
    bank_out.rdata <= mem[bank_in.raddr];
  end

endmodule

//--- hw/tim_byte_merge.sv
module tim_byte_merge (
  input tim_pkg::tim_data_t old_word,
  input tim_pkg::tim_data_t wdata,
  input tim_pkg::tim_strb_t wstrb,
  output tim_pkg::tim_data_t new_word
);

  // strobed bytes come from the core, the rest keep the stored value
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      if (wstrb[b]) begin
        new_word[b*8 +: 8] = wdata[b*8 +: 8];
      end else begin
        new_word[b*8 +: 8] = old_word[b*8 +: 8];
      end
    end
  end

endmodule

//--- hw/tim_read_select.sv
`include "tim_params.svh"

module tim_read_select (
  input tim_pkg::bank_out_t bank_out [`TIM_BANKS],
  input tim_pkg::bank_sel_t bank,
  input tim_pkg::word_idx_t word,
  input logic last_valid,
  input tim_pkg::bank_sel_t last_bank,
  input tim_pkg::word_idx_t last_word,
  input tim_pkg::tim_data_t last_data,
  output tim_pkg::tim_data_t old_word
);

  logic hit;

  // the last write landed in the bank at the edge that also registered this read,
  // so the bank still returns the word from before that write
  assign hit = last_valid && (last_bank == bank) && (last_word == word);

  assign old_word = hit ? last_data : bank_out[bank].rdata;

  // a bank index outside the array would read nothing
  always_comb begin
    if (!$isunknown(bank)) begin
      assert (32'(bank) < `TIM_BANKS)
        else $error("bank index %0d outside the bank array", bank);
    end
  end

endmodule

//--- hw/tim_ctrl.sv
`include "tim_params.svh"

module tim_ctrl (
  input logic clock,
  input logic reset,
  input tim_pkg::tim_req_t req,
  output tim_pkg::tim_rsp_t rsp,
  output tim_pkg::bank_in_t bank_in [`TIM_BANKS],
  input tim_pkg::bank_out_t bank_out [`TIM_BANKS]
);

  import tim_pkg::*;

  // access held for its answer cycle
  typedef struct packed {
    logic write;
    bank_sel_t bank;
    word_idx_t word;
    tim_data_t wdata;
    tim_strb_t wstrb;
  } pipe_t;

  // write that landed at the previous edge
  typedef struct packed {
    bank_sel_t bank;
    word_idx_t word;
    tim_data_t data;
  } last_t;

  bank_sel_t in_bank;
  word_idx_t in_word;

  logic pipe_valid_q;
  pipe_t pipe_q;

  logic last_valid_q;
  last_t last_q;

  tim_data_t old_word;
  tim_data_t new_word;
  logic wr_fire;
  logic [`TIM_BANKS-1:0] wen_vec;

  // ##############################
  // address decode
  // ##############################

  // bits 2..0 pick a byte and are dropped, upper bits wrap
  assign in_bank = req.addr[`TIM_BANK_W+2:3];
  assign in_word = req.addr[`TIM_BANK_W+`TIM_WORD_W+2:`TIM_BANK_W+3];

  always_ff @(posedge clock) begin
    if (!reset) begin
      pipe_valid_q <= 1'b0;
    end else begin
      pipe_valid_q <= req.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      pipe_q.write <= |req.wstrb;
      pipe_q.bank <= in_bank;
      pipe_q.word <= in_word;
      pipe_q.wdata <= req.wdata;
      pipe_q.wstrb <= req.wstrb;
    end
  end

  // ##############################
  // answer cycle datapath
  // ##############################

  tim_read_select tim_read_select_i (
    .bank_out(bank_out),
    .bank(pipe_q.bank),
    .word(pipe_q.word),
    .last_valid(last_valid_q),
    .last_bank(last_q.bank),
    .last_word(last_q.word),
    .last_data(last_q.data),
    .old_word(old_word)
  );

  tim_byte_merge tim_byte_merge_i (
    .old_word(old_word),
    .wdata(pipe_q.wdata),
    .wstrb(pipe_q.wstrb),
    .new_word(new_word)
  );

  assign wr_fire = pipe_valid_q && pipe_q.write;

  always_comb begin
    for (int i = 0; i < `TIM_BANKS; i++) begin
      wen_vec[i] = wr_fire && (pipe_q.bank == bank_sel_t'(i));
      bank_in[i].wen = wen_vec[i];
      bank_in[i].waddr = pipe_q.word;
      bank_in[i].wdata = new_word;
      // only the addressed bank sees the incoming read
      bank_in[i].raddr = (in_bank == bank_sel_t'(i)) ? in_word : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      last_valid_q <= 1'b0;
    end else begin
      last_valid_q <= wr_fire;  // cleared by any cycle without a write
    end
  end

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      last_q.bank <= pipe_q.bank;
      last_q.word <= pipe_q.word;
      last_q.data <= new_word;
    end
  end

  assign rsp.ready = pipe_valid_q;
  assign rsp.rdata = pipe_q.write ? '0 : old_word;  // writes answer with zero

  // ##############################
  // checks
  // ##############################

  ready_after_valid: assert property (
    @(posedge clock) disable iff (!reset) rsp.ready |-> $past(req.valid)
  ) else $error("ready without a valid in the cycle before");

  single_bank_write: assert property (
    @(posedge clock) disable iff (!reset) $onehot0(wen_vec)
  ) else $error("more than one bank written in one cycle");

endmodule

//--- hw/tim_top.sv
`include "tim_params.svh"

module tim_top (
  input logic clock,
  input logic reset,
  input logic valid,
  input tim_pkg::tim_addr_t addr,
  input tim_pkg::tim_data_t wdata,
  input tim_pkg::tim_strb_t wstrb,
  output logic ready,
  output tim_pkg::tim_data_t rdata
);

  import tim_pkg::*;

  tim_req_t req;
  tim_rsp_t rsp;

  bank_in_t bank_in [`TIM_BANKS];
  bank_out_t bank_out [`TIM_BANKS];

  // ##############################
  // processor side
  // ##############################

  assign req.valid = valid;
  assign req.addr = addr;
  assign req.wdata = wdata;
  assign req.wstrb = wstrb;

  assign ready = rsp.ready;
  assign rdata = rsp.rdata;

  // ##############################
  // controller and banks
  // ##############################

  tim_ctrl tim_ctrl_i (
    .clock(clock),
    .reset(reset),
    .req(req),
    .rsp(rsp),
    .bank_in(bank_in),
    .bank_out(bank_out)
  );

  // consecutive 64-bit words go to consecutive banks
  for (genvar i = 0; i < `TIM_BANKS; i++) begin : g_bank
    tim_bank_ram tim_bank_ram_i (
      .clock(clock),
      .bank_in(bank_in[i]),
      .bank_out(bank_out[i])
    );
  end

endmodule

//--- test/tim_tb.sv
`include "tim_params.svh"

module tim_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import tim_pkg::*;

  localparam int STREAM_LEN = 300;
  localparam int DRAIN_LIMIT = 20;
  localparam logic [31:0] SEED = 32'd1289;

  localparam logic [7:0] T_RESET = 8'd1;
  localparam logic [7:0] T_FULL = 8'd2;
  localparam logic [7:0] T_PARTIAL = 8'd3;
  localparam logic [7:0] T_FWD_READ = 8'd4;
  localparam logic [7:0] T_FWD_WRITE = 8'd5;
  localparam logic [7:0] T_STREAM = 8'd6;

  // expectation for one access, carried from its valid to its ready
  typedef struct packed {
    logic valid;
    logic write;
    tim_data_t rdata;  // the word as it stood before the access
    logic [7:0] test;
  } expect_t;

  logic clock;
  logic reset;
  logic valid;
  tim_addr_t addr;
  tim_data_t wdata;
  tim_strb_t wstrb;
  logic ready;
  tim_data_t rdata;

  expect_t issued;
  expect_t answering;
  tim_data_t model [`TIM_BANKS][`TIM_DEPTH];
  logic [31:0] rng;

  int data_errors = 0;
  int protocol_errors = 0;
  int timeout_errors = 0;

  tim_top tim_top_i (
    .clock(clock),
    .reset(reset),
    .valid(valid),
    .addr(addr),
    .wdata(wdata),
    .wstrb(wstrb),
    .ready(ready),
    .rdata(rdata)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    if (!reset) begin
      answering <= '0;
    end else begin
      answering <= issued;  // the answer comes one cycle after the valid
    end
  end

  // ##############################
  // checks
  // ##############################

  reset_quiet: assert property (@(posedge clock) !reset |=> !ready)
    else begin
      protocol_errors++;
      $display("ready went high while reset was held");
    end

  answer_on_time: assert property (
    @(posedge clock) disable iff (!reset) answering.valid |-> ready
  ) else begin
    protocol_errors++;
    $display("no ready one cycle after a valid (%s)", test_label($sampled(answering.test)));
  end

  no_stray_ready: assert property (
    @(posedge clock) disable iff (!reset) !answering.valid |-> !ready
  ) else begin
    protocol_errors++;
    $display("ready came without an access in the cycle before");
  end

  answer_data: assert property (
    @(posedge clock) disable iff (!reset)
      (answering.valid && ready) |-> (rdata == expected_rdata(answering))
  ) else begin
    data_errors++;
    $display("CHECK FAILED %s expected %h actual %h", test_label($sampled(answering.test)),
             expected_rdata($sampled(answering)), $sampled(rdata));
  end

  // ##############################
  // helpers
  // ##############################

  function automatic string test_label(input logic [7:0] id);
    case (id)
      T_RESET: return "reset";
      T_FULL: return "full_write";
      T_PARTIAL: return "partial_write";
      T_FWD_READ: return "forward_to_read";
      T_FWD_WRITE: return "forward_to_write";
      T_STREAM: return "random_stream";
      default: return "unknown";
    endcase
  endfunction

  // writes answer with zero and reads with the old word
  function automatic tim_data_t expected_rdata(input expect_t e);
    return e.write ? 64'h0 : e.rdata;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic tim_data_t merge_bytes(input tim_data_t old, input tim_data_t data,
                                            input tim_strb_t strb);
    tim_data_t result;
    result = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) result[8*b +: 8] = data[8*b +: 8];
    end
    return result;
  endfunction

  // the model is updated at issue time, so back-to-back accesses see earlier writes
  task automatic access(input logic [7:0] test, input tim_addr_t a, input tim_data_t d,
                        input tim_strb_t s);
    int idx;
    int bank;
    int word;
    tim_data_t old;
    expect_t e;
    idx = int'((a >> 3) % (`TIM_BANKS * `TIM_DEPTH));  // word address wraps
    bank = idx % `TIM_BANKS;
    word = idx / `TIM_BANKS;
    old = model[bank][word];
    if (s != 8'h00) model[bank][word] = merge_bytes(old, d, s);
    e.valid = 1'b1;
    e.write = (s != 8'h00);
    e.rdata = old;
    e.test = test;
    valid <= 1'b1;
    addr <= a;
    wdata <= d;
    wstrb <= s;
    issued <= e;
    @(posedge clock);
  endtask

  task automatic idle();
    valid <= 1'b0;
    wstrb <= '0;
    issued <= '0;
    @(posedge clock);
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((ready || answering.valid) && cycles < DRAIN_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    if (ready || answering.valid) begin
      timeout_errors++;
      $display("timeout: answers still pending after %0d cycles", DRAIN_LIMIT);
    end
  endtask

  // ##############################
  // stimulus
  // ##############################

  initial begin : stimulus
    tim_addr_t a;
    tim_strb_t s;
    logic [31:0] r_ctl;
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    reset = 1'b0;
    valid = 1'b1;  // reads are offered during reset and must get no answer
    addr = '0;
    wdata = '0;
    wstrb = '0;
    issued = '0;
    rng = SEED;
    for (int b = 0; b < `TIM_BANKS; b++) begin
      for (int w = 0; w < `TIM_DEPTH; w++) model[b][w] = '0;
    end
    repeat (5) @(posedge clock);
    reset <= 1'b1;

    idle();
    access(T_RESET, 32'h0000_0100, '0, 8'h00);  // never written
    idle();

    access(T_FULL, 32'h0000_0040, 64'h0123_4567_89ab_cdef, 8'hff);
    idle();
    access(T_FULL, 32'h0000_0040, '0, 8'h00);
    idle();

    access(T_PARTIAL, 32'h0000_0088, 64'h1111_2222_3333_4444, 8'hff);
    idle();
    access(T_PARTIAL, 32'h0000_0088, 64'haaaa_bbbb_cccc_dddd, 8'h04);
    idle();
    access(T_PARTIAL, 32'h0000_008b, 64'h5a5a_5a5a_a5a5_a5a5, 8'h81);
    idle();
    access(T_PARTIAL, 32'h0000_0088, 64'hfedc_ba98_7654_3210, 8'h3c);
    idle();
    access(T_PARTIAL, 32'h0000_0088, '0, 8'h00);
    idle();

    access(T_FWD_READ, 32'h0000_01f0, 64'hdead_beef_cafe_f00d, 8'hff);
    access(T_FWD_READ, 32'h0000_01f0, '0, 8'h00);
    access(T_FWD_READ, 32'h0000_01f4, 64'h0000_0077_0000_0000, 8'h10);
    access(T_FWD_READ, 32'h0000_01f0, '0, 8'h00);
    idle();

    access(T_FWD_WRITE, 32'h0000_0230, 64'h0102_0304_0506_0708, 8'h01);
    access(T_FWD_WRITE, 32'h0000_0230, 64'h1112_1314_1516_1718, 8'h02);
    access(T_FWD_WRITE, 32'h0000_0230, 64'h2122_2324_2526_2728, 8'hf0);
    access(T_FWD_WRITE, 32'h0000_0230, '0, 8'h00);
    idle();
    access(T_FWD_WRITE, 32'h0000_0230, '0, 8'h00);
    idle();

    // 16 hot words keep reuse high and the upper bits exercise the wrap
    for (int n = 0; n < STREAM_LEN; n++) begin
      rng = xorshift(rng);
      r_ctl = rng;
      rng = xorshift(rng);
      r_hi = rng;
      rng = xorshift(rng);
      r_lo = rng;
      a = {r_hi[31:11], 4'b0000, r_ctl[3:0], r_ctl[6:4]};
      case (r_ctl[9:8])
        2'd0: s = 8'h00;
        2'd1: s = 8'hff;
        default: s = r_ctl[23:16];
      endcase
      access(T_STREAM, a, {r_hi, r_lo}, s);
    end

    idle();
    idle();
    wait_drained();
    @(posedge clock);

    $display("errors: %0d data, %0d protocol, %0d timeout", data_errors, protocol_errors,
             timeout_errors);
    if (data_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+hw
hw/tim_pkg.sv
hw/tim_bank_ram.sv
hw/tim_byte_merge.sv
hw/tim_read_select.sv
hw/tim_ctrl.sv
hw/tim_top.sv
test/tim_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tim_tb \
  -Mdir obj_dir \
  -f sim.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "PASS: all tests"; then
  exit 0
fi

echo "simulation did not report a pass"
exit 1
